// ==== Makefile ====
TOOL     := verilator
TOP      := tb_gat_conv
FILELIST := list.f
FLAGS    := --binary --timing --assert -Wno-fatal
LINT     := --lint-only --timing -Wall
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== dmvm.sv ====
`timescale 1ns/10ps

module dmvm #(
  parameter int NUM_FEATURE_IN   = 16,
  parameter int NUM_FEATURE_OUT  = 4,
  parameter int MAX_NODES        = 8,
  localparam int NODE_W          = $clog2(MAX_NODES),
  localparam int A_DEPTH         = 2 * NUM_FEATURE_OUT,
  localparam int WH_DATA_WIDTH   = 2 * gat_pkg::DATA_WIDTH + $clog2(NUM_FEATURE_IN),
  localparam int DOT_W           = WH_DATA_WIDTH + gat_pkg::DATA_WIDTH
                                   + $clog2(NUM_FEATURE_OUT),
  localparam int SUM_W           = DOT_W + 1
) (
  input  logic                                                clk,
  input  logic                                                rst_n,

  input  logic                                                wh_vld_i,
  input  logic [NUM_FEATURE_OUT-1:0][WH_DATA_WIDTH-1:0]       wh_row_i,
  input  logic [NODE_W-1:0]                                   wh_node_i,
  input  logic                                                wh_graph_last_i,
  input  logic [A_DEPTH-1:0][gat_pkg::DATA_WIDTH-1:0]         a_vec_i,

  output logic                                                coef_vld_o,
  output logic signed [gat_pkg::COEF_WIDTH-1:0]               coef_o,
  output logic [NODE_W-1:0]                                   coef_node_o,
  output logic                                                coef_graph_last_o
);

  logic signed [DOT_W-1:0] src_dot;
  logic signed [DOT_W-1:0] dst_dot;
  logic                    s1_vld;
  logic signed [DOT_W-1:0] s1_dst;
  logic [NODE_W-1:0]       s1_node;
  logic                    s1_gl;
  logic signed [DOT_W-1:0] tgt_term;
  logic signed [SUM_W-1:0] e_sum;
  logic signed [SUM_W-1:0] e_leaky;
  logic                    sat_hi;
  logic                    sat_lo;

  always_comb begin
    src_dot = '0;
    dst_dot = '0;
    for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
      src_dot = src_dot + $signed(a_vec_i[k]) * $signed(wh_row_i[k]);
      dst_dot = dst_dot + $signed(a_vec_i[NUM_FEATURE_OUT + k]) * $signed(wh_row_i[k]);
    end
  end

  // Stage 1, target node keeps its source term for the whole subgraph
  always_ff @(posedge clk) begin
    if (wh_vld_i) begin
      s1_dst  <= dst_dot;
      s1_node <= wh_node_i;
      s1_gl   <= wh_graph_last_i;
      if (wh_node_i == '0) begin
        tgt_term <= src_dot;
      end
    end
  end

  // Stage 2 leaky slope, then clamp to the coefficient range
  assign e_sum   = tgt_term + s1_dst;
  assign e_leaky = e_sum[SUM_W-1] ? (e_sum >>> gat_pkg::LEAKY_SHIFT) : e_sum;
  assign sat_hi  = !e_leaky[SUM_W-1] && (|e_leaky[SUM_W-2:gat_pkg::COEF_WIDTH-1]);
  assign sat_lo  = e_leaky[SUM_W-1] && !(&e_leaky[SUM_W-2:gat_pkg::COEF_WIDTH-1]);

  always_ff @(posedge clk) begin
    if (s1_vld) begin
      coef_node_o       <= s1_node;
      coef_graph_last_o <= s1_gl;
      if (sat_hi) begin
        coef_o <= {1'b0, {(gat_pkg::COEF_WIDTH-1){1'b1}}};
      end else if (sat_lo) begin
        coef_o <= {1'b1, {(gat_pkg::COEF_WIDTH-1){1'b0}}};
      end else begin
        coef_o <= e_leaky[gat_pkg::COEF_WIDTH-1:0];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_vld     <= 1'b0;
      coef_vld_o <= 1'b0;
    end else begin
      s1_vld     <= wh_vld_i;
      coef_vld_o <= s1_vld;
    end
  end

  // Fixed two-cycle latency, no row dropped or invented
  assert property (@(posedge clk) disable iff (!rst_n)
    wh_vld_i |-> ##2 coef_vld_o)
    else $error("dmvm: coefficient missing two cycles after row");

  assert property (@(posedge clk) disable iff (!rst_n)
    coef_vld_o |-> $past(wh_vld_i, 2))
    else $error("dmvm: coefficient without a row");

endmodule

// ==== gat_conv.sv ====
`timescale 1ns/10ps

module gat_conv #(
  parameter int NUM_FEATURE_IN   = 16,
  parameter int NUM_FEATURE_OUT  = 4,
  parameter int MAX_NODES        = 8,
  localparam int W_DEPTH         = NUM_FEATURE_IN * NUM_FEATURE_OUT,
  localparam int A_DEPTH         = 2 * NUM_FEATURE_OUT,
  localparam int ST_ADDR_W       = $clog2((W_DEPTH > A_DEPTH) ? W_DEPTH : A_DEPTH),
  localparam int COL_W           = $clog2(NUM_FEATURE_IN),
  localparam int NODE_W          = $clog2(MAX_NODES),
  localparam int NUM_W           = $clog2(MAX_NODES + 1),
  localparam int WH_DATA_WIDTH   = 2 * gat_pkg::DATA_WIDTH + $clog2(NUM_FEATURE_IN)
) (
  input  logic                                                clk,
  input  logic                                                rst_n,

  input  logic                                                st_wr_i,
  input  gat_pkg::store_sel_e                                 st_sel_i,
  input  logic [ST_ADDR_W-1:0]                                st_addr_i,
  input  logic [gat_pkg::DATA_WIDTH-1:0]                      st_data_i,

  input  logic                                                h_vld_i,
  input  logic [COL_W-1:0]                                    h_col_i,
  input  logic signed [gat_pkg::DATA_WIDTH-1:0]               h_val_i,
  input  logic                                                h_last_i,
  input  logic                                                h_graph_last_i,

  output logic                                                wh_wr_o,
  output logic [NODE_W-1:0]                                   wh_addr_o,
  output logic [NUM_FEATURE_OUT-1:0][WH_DATA_WIDTH-1:0]       wh_data_o,
  output logic                                                coef_wr_o,
  output logic [NODE_W-1:0]                                   coef_addr_o,
  output logic signed [gat_pkg::COEF_WIDTH-1:0]               coef_data_o,
  output logic                                                graph_done_o,
  output logic [NUM_W-1:0]                                    num_nodes_o,
  output logic [gat_pkg::GRAPH_IDX_WIDTH-1:0]                 graph_idx_o
);

  logic [COL_W-1:0]                                    rd_col;
  logic [NUM_FEATURE_OUT-1:0][gat_pkg::DATA_WIDTH-1:0] w_row;
  logic [A_DEPTH-1:0][gat_pkg::DATA_WIDTH-1:0]         a_vec;

  logic                                                wh_vld;
  logic [NUM_FEATURE_OUT-1:0][WH_DATA_WIDTH-1:0]       wh_row;
  logic [NODE_W-1:0]                                   wh_node;
  logic                                                wh_graph_last;

  logic                                                coef_vld;
  logic signed [gat_pkg::COEF_WIDTH-1:0]               coef;
  logic [NODE_W-1:0]                                   coef_node;
  logic                                                coef_graph_last;

  param_store #(
    .NUM_FEATURE_IN  (NUM_FEATURE_IN),
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT)
  ) param_store_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .st_wr_i   (st_wr_i),
    .st_sel_i  (st_sel_i),
    .st_addr_i (st_addr_i),
    .st_data_i (st_data_i),
    .rd_col_i  (rd_col),
    .w_row_o   (w_row),
    .a_vec_o   (a_vec)
  );

  spmm_row #(
    .NUM_FEATURE_IN  (NUM_FEATURE_IN),
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT),
    .MAX_NODES       (MAX_NODES)
  ) spmm_row_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .h_vld_i         (h_vld_i),
    .h_col_i         (h_col_i),
    .h_val_i         (h_val_i),
    .h_last_i        (h_last_i),
    .h_graph_last_i  (h_graph_last_i),
    .w_row_i         (w_row),
    .rd_col_o        (rd_col),
    .wh_vld_o        (wh_vld),
    .wh_row_o        (wh_row),
    .wh_node_o       (wh_node),
    .wh_graph_last_o (wh_graph_last)
  );

  dmvm #(
    .NUM_FEATURE_IN  (NUM_FEATURE_IN),
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT),
    .MAX_NODES       (MAX_NODES)
  ) dmvm_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .wh_vld_i          (wh_vld),
    .wh_row_i          (wh_row),
    .wh_node_i         (wh_node),
    .wh_graph_last_i   (wh_graph_last),
    .a_vec_i           (a_vec),
    .coef_vld_o        (coef_vld),
    .coef_o            (coef),
    .coef_node_o       (coef_node),
    .coef_graph_last_o (coef_graph_last)
  );

  result_writer #(
    .NUM_FEATURE_IN  (NUM_FEATURE_IN),
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT),
    .MAX_NODES       (MAX_NODES)
  ) result_writer_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .wh_vld_i          (wh_vld),
    .wh_row_i          (wh_row),
    .wh_node_i         (wh_node),
    .coef_vld_i        (coef_vld),
    .coef_i            (coef),
    .coef_node_i       (coef_node),
    .coef_graph_last_i (coef_graph_last),
    .wh_wr_o           (wh_wr_o),
    .wh_addr_o         (wh_addr_o),
    .wh_data_o         (wh_data_o),
    .coef_wr_o         (coef_wr_o),
    .coef_addr_o       (coef_addr_o),
    .coef_data_o       (coef_data_o),
    .graph_done_o      (graph_done_o),
    .num_nodes_o       (num_nodes_o),
    .graph_idx_o       (graph_idx_o)
  );

endmodule

// ==== gat_pkg.sv ====
package gat_pkg;

  // Node feature, weight and attention entries, all signed
  localparam int DATA_WIDTH = 8;

  // Attention coefficient after leaky slope and saturation
  localparam int COEF_WIDTH = 8;

  // Negative sums are scaled by 1/8
  localparam int LEAKY_SHIFT = 3;

  // Subgraph counter on the result side
  localparam int GRAPH_IDX_WIDTH = 16;

  // Row sequencing inside a subgraph
  typedef enum logic {
    ST_TARGET   = 1'b0,
    ST_NEIGHBOR = 1'b1
  } node_state_e;

  // Parameter store write target
  typedef enum logic {
    SEL_W = 1'b0,
    SEL_A = 1'b1
  } store_sel_e;

endpackage

// ==== list.f ====
+incdir+.
gat_pkg.sv
param_store.sv
spmm_row.sv
dmvm.sv
result_writer.sv
gat_conv.sv
tb_gat_conv.sv

// ==== param_store.sv ====
`timescale 1ns/10ps

module param_store #(
  parameter int NUM_FEATURE_IN   = 16,
  parameter int NUM_FEATURE_OUT  = 4,
  localparam int W_DEPTH         = NUM_FEATURE_IN * NUM_FEATURE_OUT,
  localparam int A_DEPTH         = 2 * NUM_FEATURE_OUT,
  localparam int COL_W           = $clog2(NUM_FEATURE_IN),
  localparam int A_ADDR_W        = $clog2(A_DEPTH),
  localparam int ST_ADDR_W       = $clog2((W_DEPTH > A_DEPTH) ? W_DEPTH : A_DEPTH)
) (
  input  logic                                                clk,
  input  logic                                                rst_n,

  input  logic                                                st_wr_i,
  input  gat_pkg::store_sel_e                                 st_sel_i,
  input  logic [ST_ADDR_W-1:0]                                st_addr_i,
  input  logic [gat_pkg::DATA_WIDTH-1:0]                      st_data_i,

  input  logic [COL_W-1:0]                                    rd_col_i,
  output logic [NUM_FEATURE_OUT-1:0][gat_pkg::DATA_WIDTH-1:0] w_row_o,
  output logic [A_DEPTH-1:0][gat_pkg::DATA_WIDTH-1:0]         a_vec_o
);

  // W laid out row-major, one row per input feature
  logic [gat_pkg::DATA_WIDTH-1:0] w_mem [W_DEPTH];
  // a_src in the low half, a_dst in the high half
  logic [gat_pkg::DATA_WIDTH-1:0] a_mem [A_DEPTH];

  always_ff @(posedge clk) begin
    if (st_wr_i) begin
      case (st_sel_i)
        gat_pkg::SEL_W: w_mem[st_addr_i] <= st_data_i;
        gat_pkg::SEL_A: a_mem[st_addr_i[A_ADDR_W-1:0]] <= st_data_i;
        default: ;
      endcase
    end
  end

  // Whole W row for the column of the current beat
  always_comb begin
    for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
      w_row_o[k] = w_mem[int'(rd_col_i) * NUM_FEATURE_OUT + k];
    end
  end

  always_comb begin
    for (int k = 0; k < A_DEPTH; k++) begin
      a_vec_o[k] = a_mem[k];
    end
  end

  // Loads stay inside the selected store
  assert property (@(posedge clk) disable iff (!rst_n)
    st_wr_i |-> ((st_sel_i == gat_pkg::SEL_W) ? (int'(st_addr_i) < W_DEPTH)
                                              : (int'(st_addr_i) < A_DEPTH)))
    else $error("param_store: load address %0d out of range", st_addr_i);

endmodule

// ==== result_writer.sv ====
`timescale 1ns/10ps

module result_writer #(
  parameter int NUM_FEATURE_IN   = 16,
  parameter int NUM_FEATURE_OUT  = 4,
  parameter int MAX_NODES        = 8,
  localparam int NODE_W          = $clog2(MAX_NODES),
  localparam int NUM_W           = $clog2(MAX_NODES + 1),
  localparam int WH_DATA_WIDTH   = 2 * gat_pkg::DATA_WIDTH + $clog2(NUM_FEATURE_IN)
) (
  input  logic                                                clk,
  input  logic                                                rst_n,

  input  logic                                                wh_vld_i,
  input  logic [NUM_FEATURE_OUT-1:0][WH_DATA_WIDTH-1:0]       wh_row_i,
  input  logic [NODE_W-1:0]                                   wh_node_i,

  input  logic                                                coef_vld_i,
  input  logic signed [gat_pkg::COEF_WIDTH-1:0]               coef_i,
  input  logic [NODE_W-1:0]                                   coef_node_i,
  input  logic                                                coef_graph_last_i,

  output logic                                                wh_wr_o,
  output logic [NODE_W-1:0]                                   wh_addr_o,
  output logic [NUM_FEATURE_OUT-1:0][WH_DATA_WIDTH-1:0]       wh_data_o,

  output logic                                                coef_wr_o,
  output logic [NODE_W-1:0]                                   coef_addr_o,
  output logic signed [gat_pkg::COEF_WIDTH-1:0]               coef_data_o,

  output logic                                                graph_done_o,
  output logic [NUM_W-1:0]                                    num_nodes_o,
  output logic [gat_pkg::GRAPH_IDX_WIDTH-1:0]                 graph_idx_o
);

  // Last coefficient of the subgraph is now on the write port
  logic coef_last_q;

  always_ff @(posedge clk) begin
    if (wh_vld_i) begin
      wh_addr_o <= wh_node_i;
      wh_data_o <= wh_row_i;
    end
    if (coef_vld_i) begin
      coef_addr_o <= coef_node_i;
      coef_data_o <= coef_i;
    end
    if (coef_last_q) begin
      num_nodes_o <= NUM_W'(coef_addr_o) + NUM_W'(1);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wh_wr_o      <= 1'b0;
      coef_wr_o    <= 1'b0;
      coef_last_q  <= 1'b0;
      graph_done_o <= 1'b0;
      graph_idx_o  <= '0;
    end else begin
      wh_wr_o      <= wh_vld_i;
      coef_wr_o    <= coef_vld_i;
      coef_last_q  <= coef_vld_i && coef_graph_last_i;
      graph_done_o <= coef_last_q;
      // Index moves on once the done pulse has gone out
      if (graph_done_o) begin
        graph_idx_o <= graph_idx_o + 1'b1;
      end
    end
  end

endmodule

// ==== spmm_row.sv ====
`timescale 1ns/10ps

module spmm_row #(
  parameter int NUM_FEATURE_IN   = 16,
  parameter int NUM_FEATURE_OUT  = 4,
  parameter int MAX_NODES        = 8,
  localparam int COL_W           = $clog2(NUM_FEATURE_IN),
  localparam int NODE_W          = $clog2(MAX_NODES),
  localparam int WH_DATA_WIDTH   = 2 * gat_pkg::DATA_WIDTH + $clog2(NUM_FEATURE_IN)
) (
  input  logic                                                clk,
  input  logic                                                rst_n,

  input  logic                                                h_vld_i,
  input  logic [COL_W-1:0]                                    h_col_i,
  input  logic signed [gat_pkg::DATA_WIDTH-1:0]               h_val_i,
  input  logic                                                h_last_i,
  input  logic                                                h_graph_last_i,

  input  logic [NUM_FEATURE_OUT-1:0][gat_pkg::DATA_WIDTH-1:0] w_row_i,
  output logic [COL_W-1:0]                                    rd_col_o,

  output logic                                                wh_vld_o,
  output logic [NUM_FEATURE_OUT-1:0][WH_DATA_WIDTH-1:0]       wh_row_o,
  output logic [NODE_W-1:0]                                   wh_node_o,
  output logic                                                wh_graph_last_o
);

  logic signed [WH_DATA_WIDTH-1:0] acc     [NUM_FEATURE_OUT];
  logic signed [WH_DATA_WIDTH-1:0] acc_nxt [NUM_FEATURE_OUT];
  gat_pkg::node_state_e            state;
  logic [NODE_W-1:0]               node_cnt;
  logic [NODE_W-1:0]               cur_node;
  logic                            row_end;

  // W row is looked up by the column of the beat in flight
  assign rd_col_o = h_col_i;
  assign row_end  = h_vld_i && h_last_i;
  assign cur_node = (state == gat_pkg::ST_TARGET) ? '0 : node_cnt;

  always_comb begin
    for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
      acc_nxt[k] = acc[k] + h_val_i * $signed(w_row_i[k]);
    end
  end

  // Last beat hands the sum out and starts the next row from zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
        acc[k] <= '0;
      end
    end else if (h_vld_i) begin
      for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
        acc[k] <= h_last_i ? '0 : acc_nxt[k];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (row_end) begin
      for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
        wh_row_o[k] <= acc_nxt[k];
      end
      wh_node_o       <= cur_node;
      wh_graph_last_o <= h_graph_last_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wh_vld_o <= 1'b0;
      state    <= gat_pkg::ST_TARGET;
      node_cnt <= '0;
    end else begin
      wh_vld_o <= row_end;
      if (row_end) begin
        if (h_graph_last_i) begin
          state    <= gat_pkg::ST_TARGET;
          node_cnt <= '0;
        end else begin
          state    <= gat_pkg::ST_NEIGHBOR;
          node_cnt <= cur_node + 1'b1;
        end
      end
    end
  end

  // Subgraph closes before the node index runs past MAX_NODES
  assert property (@(posedge clk) disable iff (!rst_n)
    row_end && (cur_node == NODE_W'(MAX_NODES - 1)) |-> h_graph_last_i)
    else $error("spmm_row: subgraph longer than MAX_NODES");

  assert property (@(posedge clk) disable iff (!rst_n)
    h_vld_i && h_graph_last_i |-> h_last_i)
    else $error("spmm_row: graph-last without row-last");

endmodule

// ==== tb_gat_checks.svh ====
// Strobes stay quiet while reset is held
assert property (@(posedge clk) !rst_n && $past(!rst_n) |->
    !wh_wr_o && !coef_wr_o && !graph_done_o)
  else begin
    $display("ERROR t=%0t an output strobe is active during reset", $time);
    abort_run();
  end

// Subgraph counter tracks the done pulses seen so far, from 0
assert property (@(posedge clk) rst_n || $past(!rst_n) |->
    graph_idx_o == 16'(done_pop))
  else begin
    $display("ERROR t=%0t graph_idx_o expected %0d actual %0d", $time, done_pop, graph_idx_o);
    abort_run();
  end

// Fixed latencies from the row-end beat, no lost or extra strobes
assert property (@(posedge clk) disable iff (!rst_n)
    wh_wr_o == $past(h_vld_i && h_last_i, 2))
  else begin
    $display("ERROR t=%0t wh_wr_o is not 2 cycles after a row end", $time);
    abort_run();
  end

assert property (@(posedge clk) disable iff (!rst_n)
    coef_wr_o == $past(h_vld_i && h_last_i, 4))
  else begin
    $display("ERROR t=%0t coef_wr_o is not 4 cycles after a row end", $time);
    abort_run();
  end

assert property (@(posedge clk) disable iff (!rst_n)
    graph_done_o == $past(h_vld_i && h_graph_last_i, 5))
  else begin
    $display("ERROR t=%0t graph_done_o is not 5 cycles after a graph end", $time);
    abort_run();
  end

// Written values against the model
assert property (@(posedge clk) disable iff (!rst_n)
    wh_wr_o |-> wh_data_o == exp_wh[wh_pop])
  else begin
    $display("ERROR t=%0t wh_data_o expected %h actual %h", $time, exp_wh[wh_pop], wh_data_o);
    abort_run();
  end

assert property (@(posedge clk) disable iff (!rst_n)
    wh_wr_o |-> wh_addr_o == exp_addr[wh_pop])
  else begin
    $display("ERROR t=%0t wh_addr_o expected %0d actual %0d", $time, exp_addr[wh_pop],
             wh_addr_o);
    abort_run();
  end

assert property (@(posedge clk) disable iff (!rst_n)
    coef_wr_o |-> coef_data_o == exp_coef[coef_pop])
  else begin
    $display("ERROR t=%0t coef_data_o expected %0d actual %0d", $time, exp_coef[coef_pop],
             coef_data_o);
    abort_run();
  end

assert property (@(posedge clk) disable iff (!rst_n)
    coef_wr_o |-> coef_addr_o == exp_addr[coef_pop])
  else begin
    $display("ERROR t=%0t coef_addr_o expected %0d actual %0d", $time, exp_addr[coef_pop],
             coef_addr_o);
    abort_run();
  end

assert property (@(posedge clk) disable iff (!rst_n)
    graph_done_o |-> num_nodes_o == exp_nodes[done_pop])
  else begin
    $display("ERROR t=%0t num_nodes_o expected %0d actual %0d", $time, exp_nodes[done_pop],
             num_nodes_o);
    abort_run();
  end

// ==== tb_gat_conv.sv ====
`timescale 1ns/10ps

module tb_gat_conv;

  localparam int NUM_FEATURE_IN  = 16;
  localparam int NUM_FEATURE_OUT = 4;
  localparam int MAX_NODES       = 8;
  localparam int WH_W            = 2 * gat_pkg::DATA_WIDTH + $clog2(NUM_FEATURE_IN);
  localparam int COL_W           = $clog2(NUM_FEATURE_IN);
  localparam int NODE_W          = $clog2(MAX_NODES);
  localparam int NUM_W           = $clog2(MAX_NODES + 1);
  localparam int ST_ADDR_W       = $clog2(NUM_FEATURE_IN * NUM_FEATURE_OUT);
  localparam int COEF_MAX        = 2 ** (gat_pkg::COEF_WIDTH - 1) - 1;
  localparam int COEF_MIN        = -(2 ** (gat_pkg::COEF_WIDTH - 1));
  localparam int CLK_PERIOD      = 20;
  localparam int GRAPHS_PER_SET  = 6;
  localparam int MAX_NNZ         = 7;
  localparam int MAX_ROWS        = 2 * GRAPHS_PER_SET * MAX_NODES;
  localparam int LOAD_CYCLES     = NUM_FEATURE_IN * NUM_FEATURE_OUT + 2 * NUM_FEATURE_OUT + 2;
  // Worst-case beats plus 20 cycles per subgraph, loads, reset and margin
  localparam int WATCHDOG_CYCLES = 2 * GRAPHS_PER_SET * (MAX_NODES * MAX_NNZ + 20)
                                   + 2 * LOAD_CYCLES + 10 + 200;

  logic                                        clk = 1'b0;
  logic                                        rst_n;
  logic                                        st_wr_i;
  gat_pkg::store_sel_e                         st_sel_i;
  logic [ST_ADDR_W-1:0]                        st_addr_i;
  logic [gat_pkg::DATA_WIDTH-1:0]              st_data_i;
  logic                                        h_vld_i;
  logic [COL_W-1:0]                            h_col_i;
  logic signed [gat_pkg::DATA_WIDTH-1:0]       h_val_i;
  logic                                        h_last_i;
  logic                                        h_graph_last_i;
  logic                                        wh_wr_o;
  logic [NODE_W-1:0]                           wh_addr_o;
  logic [NUM_FEATURE_OUT-1:0][WH_W-1:0]        wh_data_o;
  logic                                        coef_wr_o;
  logic [NODE_W-1:0]                           coef_addr_o;
  logic signed [gat_pkg::COEF_WIDTH-1:0]       coef_data_o;
  logic                                        graph_done_o;
  logic [NUM_W-1:0]                            num_nodes_o;
  logic [gat_pkg::GRAPH_IDX_WIDTH-1:0]         graph_idx_o;

  // Model copies of the parameters and the row being accumulated
  int     w_m [NUM_FEATURE_IN][NUM_FEATURE_OUT];
  int     a_m [2 * NUM_FEATURE_OUT];
  longint row_acc [NUM_FEATURE_OUT];
  longint tgt_src;

  // Expected results are filled as rows are driven and drained as outputs arrive
  logic [NUM_FEATURE_OUT*WH_W-1:0]       exp_wh    [MAX_ROWS];
  logic [NODE_W-1:0]                     exp_addr  [MAX_ROWS];
  logic signed [gat_pkg::COEF_WIDTH-1:0] exp_coef  [MAX_ROWS];
  logic [NUM_W-1:0]                      exp_nodes [2 * GRAPHS_PER_SET];
  int row_push   = 0;
  int graph_push = 0;
  int wh_pop     = 0;
  int coef_pop   = 0;
  int done_pop   = 0;

  logic [31:0] lfsr = 32'd72092;

  gat_conv #(
    .NUM_FEATURE_IN  (NUM_FEATURE_IN),
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT),
    .MAX_NODES       (MAX_NODES)
  ) gat_conv_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .st_wr_i        (st_wr_i),
    .st_sel_i       (st_sel_i),
    .st_addr_i      (st_addr_i),
    .st_data_i      (st_data_i),
    .h_vld_i        (h_vld_i),
    .h_col_i        (h_col_i),
    .h_val_i        (h_val_i),
    .h_last_i       (h_last_i),
    .h_graph_last_i (h_graph_last_i),
    .wh_wr_o        (wh_wr_o),
    .wh_addr_o      (wh_addr_o),
    .wh_data_o      (wh_data_o),
    .coef_wr_o      (coef_wr_o),
    .coef_addr_o    (coef_addr_o),
    .coef_data_o    (coef_data_o),
    .graph_done_o   (graph_done_o),
    .num_nodes_o    (num_nodes_o),
    .graph_idx_o    (graph_idx_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic abort_run();
    $display("Verification failed");
    $fatal(1);
  endtask

  `include "tb_gat_checks.svh"

  always @(posedge clk) begin
    if (wh_wr_o) wh_pop <= wh_pop + 1;
    if (coef_wr_o) coef_pop <= coef_pop + 1;
    if (graph_done_o) done_pop <= done_pop + 1;
  end

  // Galois form with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr[0]);
      lfsr = lfsr_step(lfsr);
    end
    return v;
  endfunction

  function automatic int take_signed(input int n);
    int v;
    v = take_bits(n);
    if (v >= (1 << (n - 1))) v = v - (1 << n);
    return v;
  endfunction

  task automatic write_store(input gat_pkg::store_sel_e sel, input int addr, input int val);
    @(posedge clk);
    st_wr_i   <= 1'b1;
    st_sel_i  <= sel;
    st_addr_i <= addr[ST_ADDR_W-1:0];
    st_data_i <= val[gat_pkg::DATA_WIDTH-1:0];
  endtask

  task automatic load_params(input int w_bits, input int a_bits);
    for (int r = 0; r < NUM_FEATURE_IN; r++) begin
      for (int c = 0; c < NUM_FEATURE_OUT; c++) begin
        w_m[r][c] = take_signed(w_bits);
        write_store(gat_pkg::SEL_W, r * NUM_FEATURE_OUT + c, w_m[r][c]);
      end
    end
    for (int i = 0; i < 2 * NUM_FEATURE_OUT; i++) begin
      a_m[i] = take_signed(a_bits);
      write_store(gat_pkg::SEL_A, i, a_m[i]);
    end
    @(posedge clk);
    st_wr_i <= 1'b0;
  endtask

  task automatic send_beat(input int col, input int val, input bit last, input bit glast);
    @(posedge clk);
    h_vld_i        <= 1'b1;
    h_col_i        <= col[COL_W-1:0];
    h_val_i        <= val[gat_pkg::DATA_WIDTH-1:0];
    h_last_i       <= last;
    h_graph_last_i <= glast;
    for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
      row_acc[k] += val * w_m[col][k];
    end
  endtask

  // Wh row, then e_j = leaky(a_src.Wh_0 + a_dst.Wh_j) clamped to the coefficient range
  task automatic record_row(input int node, input bit glast);
    longint dst;
    longint e;
    dst = 0;
    if (node == 0) begin
      tgt_src = 0;
      for (int k = 0; k < NUM_FEATURE_OUT; k++) tgt_src += a_m[k] * row_acc[k];
    end
    for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
      exp_wh[row_push][k*WH_W +: WH_W] = row_acc[k][WH_W-1:0];
      dst += a_m[NUM_FEATURE_OUT + k] * row_acc[k];
      row_acc[k] = 0;
    end
    e = tgt_src + dst;
    if (e < 0) e = e >>> gat_pkg::LEAKY_SHIFT;
    if (e > COEF_MAX) e = COEF_MAX;
    else if (e < COEF_MIN) e = COEF_MIN;
    exp_addr[row_push] = node[NODE_W-1:0];
    exp_coef[row_push] = e[gat_pkg::COEF_WIDTH-1:0];
    row_push++;
    if (glast) begin
      exp_nodes[graph_push] = NUM_W'(node + 1);
      graph_push++;
    end
  endtask

  // Empty rows go out as a single zero beat
  task automatic send_graph(input int h_bits);
    int n;
    int nnz;
    n = take_bits(3) + 1;
    for (int j = 0; j < n; j++) begin
      nnz = take_bits(3);
      if (nnz == 0) begin
        send_beat(take_bits(COL_W), 0, 1'b1, j == n - 1);
      end else begin
        for (int b = 0; b < nnz; b++) begin
          send_beat(take_bits(COL_W), take_signed(h_bits), b == nnz - 1,
                    (b == nnz - 1) && (j == n - 1));
        end
      end
      record_row(j, j == n - 1);
    end
  endtask

  task automatic stop_stream();
    @(posedge clk);
    h_vld_i        <= 1'b0;
    h_last_i       <= 1'b0;
    h_graph_last_i <= 1'b0;
  endtask

  task automatic wait_drain();
    while (wh_pop != row_push || coef_pop != row_push || done_pop != graph_push) begin
      @(posedge clk);
    end
  endtask

  initial begin
    rst_n          = 1'b0;
    st_wr_i        = 1'b0;
    st_sel_i       = gat_pkg::SEL_W;
    st_addr_i      = '0;
    st_data_i      = '0;
    h_vld_i        = 1'b0;
    h_col_i        = '0;
    h_val_i        = '0;
    h_last_i       = 1'b0;
    h_graph_last_i = 1'b0;
    for (int k = 0; k < NUM_FEATURE_OUT; k++) row_acc[k] = 0;
    tgt_src = 0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    repeat (5) @(posedge clk);

    // Small weights first, so unsaturated and leaky values show up
    load_params(3, 3);
    for (int g = 0; g < GRAPHS_PER_SET; g++) send_graph((g % 2) ? 8 : 3);
    stop_stream();
    wait_drain();

    // Full-range weights saturate most coefficients
    load_params(8, 4);
    for (int g = 0; g < GRAPHS_PER_SET; g++) send_graph((g % 2) ? 3 : 8);
    stop_stream();
    wait_drain();
    repeat (5) @(posedge clk);

    if (int'(graph_idx_o) == graph_push) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("ERROR t=%0t graph_idx_o expected %0d actual %0d", $time, graph_push,
               graph_idx_o);
      abort_run();
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout, results did not arrive within %0d cycles", WATCHDOG_CYCLES);
    abort_run();
  end

endmodule
